// ==== hw/mem_map_pkg.sv ====
/* Memory side definitions shared by the loader, backup engine, arbiter and RAM model.
   Import wherever a request, a response or the word address map is needed. */
`default_nettype none

package mem_map_pkg;

	// ==================================================================
	// Word address map
	// ==================================================================
	localparam int MEM_AW_MAX    = 17;     // Widest word address on the bus
	localparam int WORD_W        = 16;     // Memory word, also the core bus width
	localparam int BACKUP_BASE   = 0;      // Backup region start
	localparam int ROM_WORD_BASE = 65536;  // Cartridge image word 0
	localparam int SECTOR_WORDS  = 256;    // One backup sector, sector n at n * 256

	// Arbiter channels, highest priority first
	typedef enum logic [1:0] {
		CHAN_CART   = 2'd0,  // Download writes
		CHAN_BACKUP = 2'd1,  // Sector copies
		CHAN_CORE   = 2'd2   // Emulated system bus
	} mem_chan_e;

	// ==================================================================
	// Bus payloads
	// ==================================================================

	// One request; valid is a single cycle pulse, no second one before ready
	typedef struct packed {
		logic                  valid;
		logic                  rnw;    // Read = 1, write = 0
		logic [MEM_AW_MAX-1:0] addr;   // Word address
		logic [WORD_W-1:0]     wdata;
	} mem_req_t;

	// Answer to one request
	typedef struct packed {
		logic              ready;  // One cycle high, closes the request
		logic [WORD_W-1:0] rdata;  // Read data, valid with ready
	} mem_rsp_t;

endpackage

`default_nettype wire

// ==== hw/backup_pkg.sv ====
/* Backup storage definitions: save kinds reported by the core, sector counts
   per kind and the states of the sector transfer engine. */
`default_nettype none

package backup_pkg;

	// Backup type flagged by the core on each bus access
	typedef enum logic [1:0] {
		SAVE_NONE   = 2'd0,
		SAVE_EEPROM = 2'd1,
		SAVE_SRAM   = 2'd2,
		SAVE_FLASH  = 2'd3
	} save_kind_e;

	// Sector engine, one pass per sector
	typedef enum logic [1:0] {
		BK_IDLE       = 2'd0,  // Waiting for a load or save strobe
		BK_SD_REQUEST = 2'd1,  // Raise sd_rd or sd_wr
		BK_SD_WAIT    = 2'd2,  // Host moving the sector
		BK_COPY       = 2'd3   // Buffer <-> memory, word by word
	} bk_state_e;

	localparam int SECTORS_EEPROM   = 16;   // 8 KB
	localparam int SECTORS_SRAM     = 64;   // 32 KB
	localparam int SECTORS_FLASH    = 128;  // 64 KB
	localparam int SECTORS_FLASH_1M = 256;  // 128 KB, cart carries the 1M marker

endpackage

`default_nettype wire

// ==== hw/cart_loader.sv ====
/* Cartridge download path: turns host words into ROM writes and holds the host
   with ioctl_wait until each write lands. Also keeps the image end and flash type. */
`timescale 1ns/1ps
`default_nettype none

module cart_loader #(
	parameter int MEM_AW   = mem_map_pkg::MEM_AW_MAX,     // Word address width in use
	parameter int ROM_BASE = mem_map_pkg::ROM_WORD_BASE   // Memory word of image word 0
) (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire mem_map_pkg::mem_req_t ioctl,            // valid = wr, addr = image word
	input  wire                        ioctl_download,
	output mem_map_pkg::mem_req_t      cart_req,
	input  wire mem_map_pkg::mem_rsp_t cart_rsp,
	output logic                       ioctl_wait,
	output logic [MEM_AW-1:0]          last_addr,        // Last image word of the download
	output logic                       flash_1m,
	output logic                       download_start    // One cycle at download rise
);
	import mem_map_pkg::*;

	localparam logic [71:0] FLASH_MARK = "FLASH1M_V";

	logic              dl_q;       // Download level, one cycle late
	logic              dl_write;   // Host word accepted this cycle
	logic              req_valid;
	logic [MEM_AW-1:0] req_addr;
	logic [WORD_W-1:0] req_wdata;
	logic [MEM_AW-1:0] wr_addr_q;  // Most recent image word written
	logic [63:0]       byte_tail;  // Last eight stream bytes, newest at the bottom
	logic [7:0]        byte_lo;    // First byte of the word in stream order
	logic [7:0]        byte_hi;
	logic              mark_hit;

	assign dl_write       = ioctl_download & ioctl.valid;
	assign download_start = ioctl_download & ~dl_q;
	assign byte_lo        = ioctl.wdata[7:0];
	assign byte_hi        = ioctl.wdata[15:8];

	// Marker may end on either byte of the incoming word
	assign mark_hit = ({byte_tail, byte_lo} == FLASH_MARK) ||
	                  ({byte_tail[55:0], byte_lo, byte_hi} == FLASH_MARK);

	// ==================================================================
	// Handshake and download tracking
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q       <= 1'b0;
			req_valid  <= 1'b0;
			ioctl_wait <= 1'b0;
			flash_1m   <= 1'b0;
			last_addr  <= '0;
		end else begin
			dl_q      <= ioctl_download;
			req_valid <= dl_write;                         // One memory write per host word
			if (!ioctl_download) ioctl_wait <= 1'b0;
			else if (dl_write) ioctl_wait <= 1'b1;         // Up the cycle after wr
			else if (cart_rsp.ready) ioctl_wait <= 1'b0;   // Write has landed
			if (download_start) begin                      // New image
				flash_1m  <= 1'b0;
				last_addr <= '0;
			end
			if (dl_q && !ioctl_download) last_addr <= wr_addr_q;  // Download closed
			if (dl_write && mark_hit) flash_1m <= 1'b1;
		end
	end

	// Write payload and byte history, no reset needed
	always_ff @(posedge clk_sys) begin
		if (dl_write) begin
			req_addr  <= MEM_AW'(ROM_BASE) + ioctl.addr[MEM_AW-1:0];
			req_wdata <= ioctl.wdata;
			wr_addr_q <= ioctl.addr[MEM_AW-1:0];
			byte_tail <= {byte_tail[47:0], byte_lo, byte_hi};  // Little endian words
		end
	end

	assign cart_req = '{valid: req_valid, rnw: 1'b0,
	                    addr: MEM_AW_MAX'(req_addr), wdata: req_wdata};

endmodule

`default_nettype wire

// ==== hw/backup_xfer.sv ====
/* Backup RAM engine with the sector buffer shared with the SD host, save size tracking
   and the load/save state machine that moves whole sectors between buffer and memory. */
`timescale 1ns/1ps
`default_nettype none

module backup_xfer #(
	parameter int MEM_AW = mem_map_pkg::MEM_AW_MAX
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         download_start,   // Clears the save size
	input  wire                         flash_1m,
	input  wire backup_pkg::save_kind_e core_save_kind,
	input  wire                         core_write_seen,  // Core bus valid
	input  wire                         bk_load,
	input  wire                         bk_save,
	output mem_map_pkg::mem_req_t       bk_req,
	input  wire mem_map_pkg::mem_rsp_t  bk_rsp,
	input  wire                         sd_ack,
	input  wire [7:0]                   sd_buff_addr,
	input  wire [15:0]                  sd_buff_dout,
	input  wire                         sd_buff_wr,
	output logic [15:0]                 sd_buff_din,
	output logic                        sd_rd,
	output logic                        sd_wr,
	output logic [7:0]                  sd_lba,
	output logic                        bk_pending,
	output logic                        bk_busy
);
	import mem_map_pkg::*;
	import backup_pkg::*;

	localparam logic [7:0] LAST_WORD = 8'(SECTOR_WORDS - 1);

	logic [WORD_W-1:0] sect_buf [SECTOR_WORDS];  // Dual port sector buffer
	logic [WORD_W-1:0] buf_q;                    // Memory side read, one cycle late
	logic              buf_we;
	bk_state_e         state;
	logic [7:0]        save_sz;     // Last sector index, zero = no backup seen
	logic [7:0]        kind_mask;
	logic [7:0]        word_idx;
	logic              loading;     // Current transfer is a load
	logic              req_valid;
	logic              req_wait;    // Request out, waiting for ready
	logic              load_q;
	logic              save_q;
	logic              ack_q;
	logic              load_rise;
	logic              start;
	logic [MEM_AW-1:0] word_addr;

	// Sector count - 1 for the kind seen on the bus
	always_comb begin
		case (core_save_kind)
			SAVE_EEPROM: kind_mask = 8'(SECTORS_EEPROM - 1);
			SAVE_SRAM:   kind_mask = 8'(SECTORS_SRAM - 1);
			SAVE_FLASH:  kind_mask = flash_1m ? 8'(SECTORS_FLASH_1M - 1) : 8'(SECTORS_FLASH - 1);
			default:     kind_mask = 8'd0;
		endcase
	end

	assign load_rise = bk_load & ~load_q;
	assign start     = (state == BK_IDLE) && (save_sz != 8'd0) &&
	                   (load_rise || (bk_save && !save_q));
	assign buf_we    = (state == BK_COPY) && req_wait && bk_rsp.ready && !loading;
	assign word_addr = MEM_AW'(BACKUP_BASE + sd_lba * SECTOR_WORDS + word_idx);
	assign bk_req    = '{valid: req_valid, rnw: ~loading,
	                     addr: MEM_AW_MAX'(word_addr), wdata: buf_q};

	// Port A follows word_idx, port B belongs to the SD host
	always_ff @(posedge clk_sys) begin
		if (buf_we) sect_buf[word_idx] <= bk_rsp.rdata;        // Memory into buffer on a save
		if (sd_buff_wr) sect_buf[sd_buff_addr] <= sd_buff_dout; // Host fills the sector on a load
		buf_q       <= sect_buf[word_idx];
		sd_buff_din <= sect_buf[sd_buff_addr];
	end

	// ==================================================================
	// Save size and pending flag
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			save_sz    <= 8'd0;
			bk_pending <= 1'b0;
		end else begin
			if (download_start) save_sz <= 8'd0;
			else if (core_write_seen) save_sz <= save_sz | kind_mask;  // Only grows
			if (core_write_seen && core_save_kind != SAVE_NONE) bk_pending <= 1'b1;
			else if (start) bk_pending <= 1'b0;
		end
	end

	// ==================================================================
	// Sector state machine
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= BK_IDLE;
			load_q    <= 1'b0;
			save_q    <= 1'b0;
			ack_q     <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			bk_busy   <= 1'b0;
			loading   <= 1'b0;
			req_valid <= 1'b0;
			req_wait  <= 1'b0;
			sd_lba    <= 8'd0;
			word_idx  <= 8'd0;
		end else begin
			load_q    <= bk_load;
			save_q    <= bk_save;
			ack_q     <= sd_ack;
			req_valid <= 1'b0;
			if (sd_ack && !ack_q) begin  // Host took the command
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			case (state)
				BK_IDLE: if (start) begin
					bk_busy  <= 1'b1;
					loading  <= load_rise;            // Load wins a tie
					sd_lba   <= 8'd0;
					word_idx <= 8'd0;
					req_wait <= 1'b0;
					state    <= load_rise ? BK_SD_REQUEST : BK_COPY;
				end
				BK_SD_REQUEST: begin
					sd_rd <= loading;
					sd_wr <= ~loading;
					state <= BK_SD_WAIT;
				end
				BK_SD_WAIT: if (!sd_ack && ack_q) begin   // Sector done on ack fall
					if (loading) state <= BK_COPY;
					else if (sd_lba == save_sz) begin
						bk_busy <= 1'b0;
						state   <= BK_IDLE;
					end else begin
						sd_lba <= sd_lba + 8'd1;
						state  <= BK_COPY;
					end
				end
				BK_COPY: if (!req_wait) begin
					req_valid <= 1'b1;                   // buf_q is settled by now
					req_wait  <= 1'b1;
				end else if (bk_rsp.ready) begin
					req_wait <= 1'b0;
					word_idx <= word_idx + 8'd1;         // Wraps to 0 after the last word
					if (word_idx == LAST_WORD) begin
						if (!loading) state <= BK_SD_REQUEST;
						else if (sd_lba == save_sz) begin
							bk_busy <= 1'b0;
							state   <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 8'd1;
							state  <= BK_SD_REQUEST;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
/* Fixed priority arbiter for the shared memory: cart, then backup, then core.
   One transaction in flight; ready returns one cycle after the RAM answers. */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire mem_map_pkg::mem_req_t cart_req,
	input  wire mem_map_pkg::mem_req_t bk_req,
	input  wire mem_map_pkg::mem_req_t core_req,
	output mem_map_pkg::mem_rsp_t      cart_rsp,
	output mem_map_pkg::mem_rsp_t      bk_rsp,
	output mem_map_pkg::mem_rsp_t      core_rsp,
	output mem_map_pkg::mem_req_t      ram_req,
	input  wire mem_map_pkg::mem_rsp_t ram_rsp
);
	import mem_map_pkg::*;

	localparam int NUM_CHAN = 3;

	mem_req_t            in_req [NUM_CHAN];  // Live requests by channel
	mem_req_t            held   [NUM_CHAN];  // Latched copy until granted
	logic [NUM_CHAN-1:0] pend;
	logic [NUM_CHAN-1:0] want;               // Pending or arriving now
	logic [NUM_CHAN-1:0] rdy_q;
	logic [WORD_W-1:0]   rdata_q;
	logic                busy;
	logic                ram_valid;
	mem_req_t            ram_cmd;
	mem_chan_e           grant_q;
	mem_chan_e           sel_chan;
	logic                sel_hit;
	mem_req_t            sel_req;

	assign in_req[CHAN_CART]   = cart_req;
	assign in_req[CHAN_BACKUP] = bk_req;
	assign in_req[CHAN_CORE]   = core_req;
	assign want = pend | {core_req.valid, bk_req.valid, cart_req.valid};

	always_comb begin
		sel_hit  = 1'b1;
		sel_chan = CHAN_CART;
		if (want[CHAN_CART]) sel_chan = CHAN_CART;
		else if (want[CHAN_BACKUP]) sel_chan = CHAN_BACKUP;
		else if (want[CHAN_CORE]) sel_chan = CHAN_CORE;
		else sel_hit = 1'b0;
	end

	// A request arriving on an idle arbiter goes straight through
	assign sel_req = in_req[sel_chan].valid ? in_req[sel_chan] : held[sel_chan];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pend      <= '0;
			busy      <= 1'b0;
			rdy_q     <= '0;
			ram_valid <= 1'b0;
			grant_q   <= CHAN_CART;
		end else begin
			pend      <= want;
			rdy_q     <= '0;
			ram_valid <= 1'b0;
			if (!busy && sel_hit) begin
				pend[sel_chan] <= 1'b0;
				busy           <= 1'b1;
				grant_q        <= sel_chan;
				ram_valid      <= 1'b1;      // Single cycle valid to the RAM
			end
			if (ram_rsp.ready) begin
				rdy_q[grant_q] <= 1'b1;      // Only the owner sees ready
				busy           <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int c = 0; c < NUM_CHAN; c++) begin
			if (in_req[c].valid) held[c] <= in_req[c];
		end
		if (!busy && sel_hit) ram_cmd <= sel_req;
		if (ram_rsp.ready) rdata_q <= ram_rsp.rdata;
	end

	assign ram_req  = '{valid: ram_valid, rnw: ram_cmd.rnw, addr: ram_cmd.addr,
	                    wdata: ram_cmd.wdata};
	assign cart_rsp = '{ready: rdy_q[CHAN_CART], rdata: rdata_q};
	assign bk_rsp   = '{ready: rdy_q[CHAN_BACKUP], rdata: rdata_q};
	assign core_rsp = '{ready: rdy_q[CHAN_CORE], rdata: rdata_q};

endmodule

`default_nettype wire

// ==== hw/shared_ram.sv ====
/* Synchronous word memory behind the arbiter. Ready comes exactly two cycles
   after valid; requests pipeline, so back-to-back ones may overlap. */
`timescale 1ns/1ps
`default_nettype none

module shared_ram #(
	parameter int MEM_AW = mem_map_pkg::MEM_AW_MAX
) (
	input  wire                        clk_sys,
	input  wire mem_map_pkg::mem_req_t ram_req,
	output mem_map_pkg::mem_rsp_t      ram_rsp
);
	import mem_map_pkg::*;

	logic [WORD_W-1:0] mem [2**MEM_AW];
	logic [MEM_AW-1:0] addr;
	logic              s1_valid;  // Stage 1 holds the array access
	logic [WORD_W-1:0] s1_rdata;

	assign addr = ram_req.addr[MEM_AW-1:0];

	always_ff @(posedge clk_sys) begin
		if (ram_req.valid && !ram_req.rnw) mem[addr] <= ram_req.wdata;
		s1_valid <= ram_req.valid;
		s1_rdata <= mem[addr];        // Old data on a write, ignored by peers
		// Stage 2 drives the answer
		ram_rsp.ready <= s1_valid;
		ram_rsp.rdata <= s1_rdata;
	end

endmodule

`default_nettype wire

// ==== hw/gba_mem_top.sv ====
/* Shared memory subsystem top: cartridge loader, backup engine and core port
   arbitrated onto one RAM. Sets the address width and the ROM base for all blocks. */
`timescale 1ns/1ps
`default_nettype none

module gba_mem_top #(
	parameter int MEM_AW   = mem_map_pkg::MEM_AW_MAX,     // 128K words
	parameter int ROM_BASE = mem_map_pkg::ROM_WORD_BASE   // ROM above the backup region
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire mem_map_pkg::mem_req_t  ioctl,           // Download write
	input  wire                         ioctl_download,
	output wire                         ioctl_wait,
	input  wire mem_map_pkg::mem_req_t  core_req,
	output wire mem_map_pkg::mem_rsp_t  core_rsp,
	input  wire backup_pkg::save_kind_e core_save_kind,
	output wire [MEM_AW-1:0]            cart_last_addr,
	output wire                         cart_flash_1m,
	input  wire                         bk_load,
	input  wire                         bk_save,
	output wire                         bk_pending,
	output wire                         bk_busy,
	output wire                         sd_rd,
	output wire                         sd_wr,
	output wire [7:0]                   sd_lba,
	input  wire                         sd_ack,
	input  wire [7:0]                   sd_buff_addr,
	input  wire [15:0]                  sd_buff_dout,
	input  wire                         sd_buff_wr,
	output wire [15:0]                  sd_buff_din
);
	import mem_map_pkg::*;

	wire mem_req_t cart_req;
	wire mem_rsp_t cart_rsp;
	wire mem_req_t bk_req;
	wire mem_rsp_t bk_rsp;
	wire mem_req_t ram_req;
	wire mem_rsp_t ram_rsp;
	wire           download_start;

	cart_loader #(.MEM_AW(MEM_AW), .ROM_BASE(ROM_BASE)) i_cart_loader (
		.clk_sys, .reset, .ioctl, .ioctl_download, .cart_req, .cart_rsp, .ioctl_wait,
		.last_addr(cart_last_addr), .flash_1m(cart_flash_1m), .download_start);

	backup_xfer #(.MEM_AW(MEM_AW)) i_backup_xfer (
		.clk_sys, .reset, .download_start, .flash_1m(cart_flash_1m), .core_save_kind,
		.core_write_seen(core_req.valid), .bk_load, .bk_save, .bk_req, .bk_rsp, .sd_ack,
		.sd_buff_addr, .sd_buff_dout, .sd_buff_wr, .sd_buff_din, .sd_rd, .sd_wr, .sd_lba,
		.bk_pending, .bk_busy);

	mem_arbiter i_mem_arbiter (
		.clk_sys, .reset, .cart_req, .bk_req, .core_req, .cart_rsp, .bk_rsp, .core_rsp,
		.ram_req, .ram_rsp);

	shared_ram #(.MEM_AW(MEM_AW)) i_shared_ram (.clk_sys, .ram_req, .ram_rsp);

endmodule

`default_nettype wire

// ==== test/tb_gba_mem_top.sv ====
/* Testbench for the shared memory subsystem. Applies a stimulus table covering download,
   core access, backup save/load and idle strobes, with an SD host model on the sector port. */
`timescale 1ns/1ps
`default_nettype none

module tb_gba_mem_top;
	import mem_map_pkg::*;
	import backup_pkg::*;

	localparam int MEM_AW   = 17;
	localparam int ROM_BASE = 65536;
	localparam int MAX_ROWS = 16;
	localparam logic [71:0] MARK = "FLASH1M_V";  // Flash 1M signature in the image

	typedef enum logic [2:0] {
		OP_DOWNLOAD,     // addr = marker word, data = word count, flag = marker present
		OP_WRITE,        // Core write of an LFSR word, flag = bk_pending after
		OP_READ,         // Core read against the model
		OP_SAVE,         // data = sectors expected
		OP_LOAD,         // data = sectors expected
		OP_STROBE_IDLE   // Strobes with zero save size
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [16:0] addr;
		logic [15:0] data;
		save_kind_e  kind;
		logic        flag;
	} row_t;

	logic clk_sys = 1'b0;
	logic reset;
	logic ioctl_download;
	logic bk_load;
	logic bk_save;
	logic sd_ack;
	logic sd_buff_wr;
	logic [7:0] sd_buff_addr;
	logic [15:0] sd_buff_dout;
	mem_req_t ioctl;
	mem_req_t core_req;
	save_kind_e core_save_kind;
	wire ioctl_wait;
	wire cart_flash_1m;
	wire bk_pending;
	wire bk_busy;
	wire sd_rd;
	wire sd_wr;
	wire mem_rsp_t core_rsp;
	wire [MEM_AW-1:0] cart_last_addr;
	wire [7:0] sd_lba;
	wire [15:0] sd_buff_din;

	row_t        stim [MAX_ROWS];
	int          num_rows = 0;
	int          errors = 0;
	int          sectors_seen;               // Sectors moved by the SD host
	logic        host_load;                  // Direction the host expects
	logic [31:0] lfsr = 32'h3f1c;
	logic [15:0] model [2**MEM_AW];          // Expected memory contents
	logic [15:0] sd_store [SECTORS_SRAM * SECTOR_WORDS];  // SD card image

	always #50 clk_sys = ~clk_sys;           // 100 ns period

	gba_mem_top #(.MEM_AW(MEM_AW), .ROM_BASE(ROM_BASE)) i_gba_mem_top (
		.clk_sys, .reset, .ioctl, .ioctl_download, .ioctl_wait, .core_req, .core_rsp,
		.core_save_kind, .cart_last_addr, .cart_flash_1m, .bk_load, .bk_save, .bk_pending,
		.bk_busy, .sd_rd, .sd_wr, .sd_lba, .sd_ack, .sd_buff_addr, .sd_buff_dout,
		.sd_buff_wr, .sd_buff_din);

	// ==================================================================
	// Helpers
	// ==================================================================
	function automatic logic lfsr_bit();     // One Galois step per bit
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [15:0] rand_word();
		logic [15:0] w;
		w = '0;
		for (int b = 0; b < 16; b++) w = {w[14:0], lfsr_bit()};
		return w;
	endfunction

	// Low byte goes first in the stream
	function automatic logic [15:0] marker_word(input int j);
		if (j < 4) return {MARK[71-8*(2*j+1) -: 8], MARK[71-8*(2*j) -: 8]};
		return {8'h00, MARK[7:0]};           // Trailing V
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic report_error(input string what);
		errors++;
		$display("ERROR %s at %0t", what, $time);
	endtask

	task automatic add_row(input op_e op, input logic [16:0] addr, input logic [15:0] data,
			input save_kind_e kind, input logic flag);
		stim[num_rows].op   = op;
		stim[num_rows].addr = addr;
		stim[num_rows].data = data;
		stim[num_rows].kind = kind;
		stim[num_rows].flag = flag;
		num_rows++;
	endtask

	function automatic int table_words();   // Memory words touched by the table
		int w;
		w = 0;
		for (int i = 0; i < num_rows; i++) begin
			case (stim[i].op)
				OP_DOWNLOAD:    w += 2 * stim[i].data;                  // Write, then read back
				OP_SAVE:        w += stim[i].data * SECTOR_WORDS;
				OP_LOAD:        w += 2 * stim[i].data * SECTOR_WORDS;   // Load plus read back
				OP_STROBE_IDLE: w += 32;
				default:        w += 1;
			endcase
		end
		return w;
	endfunction

	task automatic core_access(input logic rnw, input logic [16:0] addr,
			input logic [15:0] wdata, input save_kind_e kind, output logic [15:0] rdata);
		int n;
		core_req.valid = 1'b1;               // One cycle pulse
		core_req.rnw   = rnw;
		core_req.addr  = addr;
		core_req.wdata = wdata;
		core_save_kind = kind;
		@(posedge clk_sys); #5;
		core_req.valid = 1'b0;
		core_save_kind = SAVE_NONE;
		n = 0;
		do begin
			@(posedge clk_sys); #5;
			n++;
		end while (!core_rsp.ready && n < 64);
		if (!core_rsp.ready) report_error("core port gave no ready");
		rdata = core_rsp.rdata;
	endtask

	task automatic read_check(input logic [16:0] addr);
		logic [15:0] got;
		core_access(1'b1, addr, 16'h0000, SAVE_NONE, got);
		if (got !== model[addr]) report_mismatch("core_rsp.rdata", got, model[addr]);
	endtask

	task automatic download(input int count, input int mark_at, input logic embed);
		logic [15:0] word;
		int n;
		ioctl_download = 1'b1;
		@(posedge clk_sys); #5;
		for (int i = 0; i < count; i++) begin
			if (embed && i >= mark_at && i <= mark_at + 4) word = marker_word(i - mark_at);
			else word = rand_word();
			model[ROM_BASE + i] = word;
			ioctl.valid = 1'b1;
			ioctl.rnw   = 1'b0;
			ioctl.addr  = 17'(i);
			ioctl.wdata = word;
			@(posedge clk_sys); #5;
			ioctl.valid = 1'b0;
			if (ioctl_wait !== 1'b1) report_mismatch("ioctl_wait", ioctl_wait, 1);
			n = 0;
			while (ioctl_wait && n < 64) begin  // Back-pressure from the loader
				@(posedge clk_sys); #5;
				n++;
			end
			if (ioctl_wait) report_error("ioctl_wait never fell");
		end
		ioctl_download = 1'b0;
		repeat (2) @(posedge clk_sys);       // Last address latched on the fall
		#5;
	endtask

	task automatic run_backup(input logic load, input int sectors);
		int n;
		sectors_seen = 0;
		host_load    = load;
		if (load) bk_load = 1'b1;
		else bk_save = 1'b1;
		@(posedge clk_sys); #5;
		bk_load = 1'b0;
		bk_save = 1'b0;
		if (!bk_busy) report_error("backup strobe was not accepted");
		n = 0;
		while (bk_busy && n < sectors * SECTOR_WORDS * 40) begin
			@(posedge clk_sys); #5;
			n++;
		end
		if (bk_busy) report_error("backup transfer never finished");
		if (sectors_seen != sectors) report_mismatch("sector count", sectors_seen, sectors);
	endtask

	task automatic strobe_idle(input logic load);
		logic moved;
		moved = 1'b0;
		sectors_seen = 0;
		if (load) bk_load = 1'b1;
		else bk_save = 1'b1;
		@(posedge clk_sys); #5;
		bk_load = 1'b0;
		bk_save = 1'b0;
		for (int n = 0; n < 16; n++) begin
			if (sd_rd || sd_wr || bk_busy) moved = 1'b1;
			@(posedge clk_sys); #5;
		end
		if (moved || sectors_seen != 0) report_error("strobe with zero save size ran a transfer");
	endtask

	// ==================================================================
	// SD host model, one sector per command
	// ==================================================================
	initial begin : sd_host
		int base;
		logic [7:0] lba;
		sd_ack       = 1'b0;
		sd_buff_addr = 8'd0;
		sd_buff_dout = 16'h0000;
		sd_buff_wr   = 1'b0;
		forever begin
			@(posedge clk_sys); #5;
			if (sd_rd || sd_wr) begin
				lba  = sd_lba;
				base = int'(lba) * SECTOR_WORDS;
				if (sd_rd !== host_load) report_error("SD command in the wrong direction");
				if (lba !== 8'(sectors_seen)) report_mismatch("sd_lba", lba, sectors_seen);
				sd_ack = 1'b1;                   // Clears the command level
				for (int i = 0; i < SECTOR_WORDS; i++) begin
					sd_buff_addr = 8'(i);
					sd_buff_dout = sd_store[base + i];
					sd_buff_wr   = host_load;
					@(posedge clk_sys); #5;
					if (!host_load) sd_store[base + i] = sd_buff_din;  // One cycle read latency
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;               // Sector done on the fall
				sectors_seen++;
			end
		end
	end

	initial begin : watchdog
		longint limit;
		#1;
		limit = 64'(table_words()) * 40 + 4000;
		#(limit * 100);
		$display("ERROR watchdog expired after %0d cycles", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin : main
		row_t r;
		logic [15:0] word;
		logic [15:0] got;
		add_row(OP_DOWNLOAD, 17'd0, 16'd24, SAVE_NONE, 1'b0);
		add_row(OP_DOWNLOAD, 17'd9, 16'd40, SAVE_NONE, 1'b1);   // Marker at words 9..13
		add_row(OP_WRITE, 17'h00100, 16'd0, SAVE_NONE, 1'b0);
		add_row(OP_READ, 17'h00100, 16'd0, SAVE_NONE, 1'b0);
		add_row(OP_WRITE, 17'h002a5, 16'd0, SAVE_SRAM, 1'b1);   // Sets pending and size
		add_row(OP_READ, 17'h002a5, 16'd0, SAVE_NONE, 1'b0);
		add_row(OP_WRITE, 17'h03fff, 16'd0, SAVE_NONE, 1'b1);
		add_row(OP_SAVE, 17'd0, 16'd64, SAVE_NONE, 1'b0);
		add_row(OP_LOAD, 17'd0, 16'd64, SAVE_NONE, 1'b0);
		add_row(OP_DOWNLOAD, 17'd0, 16'd8, SAVE_NONE, 1'b0);    // Clears the save size
		add_row(OP_STROBE_IDLE, 17'd0, 16'd0, SAVE_NONE, 1'b0);
		reset          = 1'b1;
		ioctl          = '0;
		ioctl_download = 1'b0;
		core_req       = '0;
		core_save_kind = SAVE_NONE;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		host_load      = 1'b0;
		sectors_seen   = 0;
		repeat (4) @(posedge clk_sys);
		#5 reset = 1'b0;
		@(posedge clk_sys); #5;
		if (ioctl_wait !== 1'b0) report_mismatch("ioctl_wait", ioctl_wait, 0);
		if (sd_rd !== 1'b0) report_mismatch("sd_rd", sd_rd, 0);
		if (sd_wr !== 1'b0) report_mismatch("sd_wr", sd_wr, 0);
		if (bk_busy !== 1'b0) report_mismatch("bk_busy", bk_busy, 0);
		if (bk_pending !== 1'b0) report_mismatch("bk_pending", bk_pending, 0);
		if (core_rsp.ready !== 1'b0) report_mismatch("core_rsp.ready", core_rsp.ready, 0);

		for (int i = 0; i < num_rows; i++) begin
			r = stim[i];
			case (r.op)
				OP_DOWNLOAD: begin
					download(r.data, r.addr, r.flag);
					if (cart_last_addr !== 17'(r.data - 1))
						report_mismatch("cart_last_addr", cart_last_addr, r.data - 1);
					if (cart_flash_1m !== r.flag)
						report_mismatch("cart_flash_1m", cart_flash_1m, r.flag);
					for (int a = 0; a < r.data; a++) read_check(17'(ROM_BASE + a));
				end
				OP_WRITE: begin
					word = rand_word();
					core_access(1'b0, r.addr, word, r.kind, got);
					model[r.addr] = word;
					if (bk_pending !== r.flag) report_mismatch("bk_pending", bk_pending, r.flag);
				end
				OP_READ: read_check(r.addr);
				OP_SAVE: begin
					run_backup(1'b0, r.data);
					if (bk_pending !== 1'b0) report_mismatch("bk_pending", bk_pending, 0);
					for (int k = 0; k < r.data * SECTOR_WORDS; k++) begin
						if (sd_store[k] !== model[k])
							report_mismatch("sd_buff_din", sd_store[k], model[k]);
					end
				end
				OP_LOAD: begin
					for (int k = 0; k < r.data * SECTOR_WORDS; k++) begin  // Fresh card image
						sd_store[k] = rand_word();
						model[k]    = sd_store[k];
					end
					run_backup(1'b1, r.data);
					for (int k = 0; k < r.data * SECTOR_WORDS; k++) read_check(17'(k));
				end
				default: begin
					strobe_idle(1'b0);
					strobe_idle(1'b1);
				end
			endcase
		end

		$display("Run complete with %0d error(s) over %0d table rows", errors, num_rows);
		if (errors == 0) $display("SIMULATION PASSED");
		else $display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/mem_map_pkg.sv
hw/backup_pkg.sv
hw/cart_loader.sv
hw/backup_xfer.sv
hw/mem_arbiter.sv
hw/shared_ram.sv
hw/gba_mem_top.sv
test/tb_gba_mem_top.sv
